// File: rtl/fetch_settings.svh
/*
 * Build settings of the instruction fetch unit.
 * Included by the package and by every RTL block that sizes a port or register.
 */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ------------------------------------------------
// address space
// ------------------------------------------------
// byte address width of the fetch port and the pc
`define FETCH_ADDR_W 32

// first fetch address after reset
`define FETCH_RESET_VEC 32'h0000_0000

// ------------------------------------------------
// return buffer
// ------------------------------------------------
// number of word slots, the buffer logic is written for two
`define FETCH_BUF_DEPTH 2

`endif

// File: rtl/fetch_pkg.sv
/*
 * Types shared by the fetch unit blocks.
 * FSM state, the fetched word view and the structs passed between blocks.
 */
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

  // ------------------------------------------------
  // fetch FSM
  // ------------------------------------------------
  typedef enum logic [2:0] {
    st_reset   = 3'd0,
    // pc word aligned, op starts in low half
    st_low     = 3'd1,
    // compressed op sitting in the saved upper half
    st_high    = 3'd2,
    // 32-bit op spanning saved upper half and next low half
    st_unalign = 3'd3,
    // first word after a jump to a halfword target
    st_exit    = 3'd4
  } fetch_state_e;

  // one fetched word, read whole or as two halves
  typedef union packed {
    logic [31:0] op;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } half;
  } insn_word_u;

  // ------------------------------------------------
  // inter-block structs
  // ------------------------------------------------
  // memory return side
  typedef struct packed {
    logic        rdy;
    logic [31:0] rdata;
  } mem_rsp_t;

  // buffer fill state, idx marks the older slot
  typedef struct packed {
    logic [`FETCH_BUF_DEPTH-1:0] valid;
    logic                        idx;
  } buf_stat_t;

  // buffer commands from the FSM
  typedef struct packed {
    logic ext_save;
    logic clear;
    logic flush;
    logic int_save;
  } buf_cmd_t;

  // instruction handed to the consumer
  typedef struct packed {
    logic                     valid;
    logic                     rv;
    logic [31:0]              op;
    logic [`FETCH_ADDR_W-1:0] pc;
  } issue_t;

endpackage

`default_nettype wire

// File: rtl/fetch_ctrl.sv
/*
 * Fetch FSM.
 * Classifies the halves of the current word, steps through low, high and
 * unaligned, and commands the return buffer. Also forms the valid and the
 * consume level for the issue block.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  wire                        clk_i,
  input  wire                        rst_an_i,
  input  wire fetch_pkg::mem_rsp_t   rsp_i,
  input  wire fetch_pkg::buf_stat_t  stat_i,
  input  wire fetch_pkg::insn_word_u word_i,
  input  wire                        drop_i,
  input  wire                        stall_i,
  input  wire                        branch_i,
  input  wire                        jump_half_i,
  output fetch_pkg::fetch_state_e    state_o,
  output logic                       advance_o,
  output logic                       valid_o,
  output fetch_pkg::buf_cmd_t        cmd_o
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         rdy_s;
  logic         buf_any_s;
  logic         lo_rv_s;
  logic         hi_rv_s;
  logic         wait_unalign_s;
  logic         valid_s;
  logic         consume_s;
  logic         step_s;
  logic         clear_s;
  logic         flush_s;
  logic         ext_save_s;
  logic         int_save_s;

  // ------------------------------------------------
  // decode helpers
  // ------------------------------------------------
  // returned data that belongs to the current stream
  assign rdy_s     = rsp_i.rdy & ~drop_i;
  assign buf_any_s = |stat_i.valid;

  // lowest two bits 11 mark a 32-bit op
  assign lo_rv_s = (word_i.half.lo[1:0] == 2'b11);
  assign hi_rv_s = (word_i.half.hi[1:0] == 2'b11);

  // halfword jump target starting a 32-bit op needs the next word too
  assign wait_unalign_s = hi_rv_s & (state_q == st_exit);

  // high state always has its op in the saved half
  // nothing is offered while a branch redirects
  assign valid_s = ((((rdy_s | buf_any_s) & ~wait_unalign_s)) | (state_q == st_high)) &
                   ~branch_i;
  assign consume_s = valid_s & ~stall_i;

  // FSM moves on a consume, and unconditionally out of reset and jump exit
  assign step_s = consume_s | (state_q == st_reset) | (state_q == st_exit);

  // ------------------------------------------------
  // next state and buffer commands
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    clear_s = 1'b0;
    flush_s = 1'b0;
    if (branch_i) begin
      // all buffered data is stale after a jump
      state_d = jump_half_i ? st_exit : st_low;
      flush_s = 1'b1;
    end else if (step_s) begin
      case (state_q)
        st_reset: begin
          state_d = st_low;
        end
        st_low: begin
          // current word leaves the buffer, its upper half may be saved
          clear_s = 1'b1;
          if (!lo_rv_s) begin
            state_d = hi_rv_s ? st_unalign : st_high;
          end
        end
        st_high: begin
          // next word is still buffered and now aligned
          state_d = st_low;
        end
        st_unalign: begin
          clear_s = 1'b1;
          if (!hi_rv_s) begin
            state_d = st_high;
          end
        end
        st_exit: begin
          // only the first word of the new stream decides
          if (rdy_s) begin
            if (hi_rv_s) begin
              state_d = st_unalign;
            end else if (stall_i) begin
              // keep the compressed op around in the saved half
              state_d = st_high;
            end else begin
              state_d = st_low;
            end
          end
        end
        default: begin
          state_d = st_reset;
        end
      endcase
    end
  end

  // save returned word unless it is used straight from the bus
  assign ext_save_s = rdy_s & (state_q != st_exit) &
                      (~consume_s | buf_any_s | (state_q == st_high));

  // keep upper half whenever the next state reads it
  assign int_save_s = step_s & ~branch_i & (state_d != st_low) & (state_q != st_high);

  always_ff @(posedge clk_i or negedge rst_an_i) begin
    if (!rst_an_i) begin
      state_q <= st_reset;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o   = state_q;
  assign advance_o = consume_s;
  assign valid_o   = valid_s;
  assign cmd_o     = '{ext_save: ext_save_s, clear: clear_s, flush: flush_s,
                       int_save: int_save_s};

endmodule

`default_nettype wire

// File: rtl/fetch_req.sv
/*
 * Memory request side of the fetch unit.
 * Raises the read strobe, tracks the single outstanding fetch, marks data
 * from before a jump for dropping and forms the next aligned word address.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_req (
  input  wire                           clk_i,
  input  wire                           rst_an_i,
  input  wire fetch_pkg::fetch_state_e  state_i,
  input  wire fetch_pkg::buf_stat_t     stat_i,
  input  wire fetch_pkg::mem_rsp_t      rsp_i,
  input  wire                           branch_i,
  input  wire [`FETCH_ADDR_W-1:0]       jump_addr_i,
  input  wire [`FETCH_ADDR_W-1:0]       pc_i,
  input  wire                           i_grant_i,
  output logic                          i_rd_o,
  output logic [`FETCH_ADDR_W-1:0]      i_addr_o,
  output logic                          drop_o
);

  import fetch_pkg::*;

  localparam int AW = `FETCH_ADDR_W;

  logic          inflight_q;
  logic          drop_q;
  logic          live_s;
  logic          held_s;
  logic          skip_s;
  logic [1:0]    offs_s;
  logic [AW-3:0] next_word_s;
  logic          rd_s;

  // outstanding fetch that still counts for the stream
  assign live_s = inflight_q & ~drop_q;
  // one word beyond the pc word is already on its way or buffered
  assign held_s = live_s | (|stat_i.valid);
  // at a halfword pc the pc word sits in the saved half, except on jump exit
  assign skip_s = pc_i[1] & (state_i != st_exit);
  assign offs_s = {1'b0, skip_s} + {1'b0, held_s};

  // ------------------------------------------------
  // read strobe
  // ------------------------------------------------
  // one outstanding fetch at most, a returning one frees the slot
  // a jump ignores fill level as the buffer is flushed
  assign rd_s = (state_i != st_reset) &
                (~inflight_q | rsp_i.rdy) &
                (branch_i | ~((live_s & (|stat_i.valid)) | (&stat_i.valid)));

  // jump target word right away, otherwise relative to the pc word
  assign next_word_s = branch_i ? jump_addr_i[AW-1:2] :
                       pc_i[AW-1:2] + (AW-2)'(offs_s);

  // ------------------------------------------------
  // in-flight and drop tracking
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_an_i) begin
    if (!rst_an_i) begin
      inflight_q <= 1'b0;
      drop_q     <= 1'b0;
    end else begin
      // new grant wins over a same-cycle return
      if (rd_s && i_grant_i) begin
        inflight_q <= 1'b1;
      end else if (rsp_i.rdy) begin
        inflight_q <= 1'b0;
      end
      // fetch still out when the jump came belongs to the old stream
      if (branch_i && inflight_q && !rsp_i.rdy) begin
        drop_q <= 1'b1;
      end else if (rsp_i.rdy) begin
        drop_q <= 1'b0;
      end
    end
  end

  assign i_rd_o   = rd_s;
  assign i_addr_o = {next_word_s, 2'b00};
  assign drop_o   = drop_q;

endmodule

`default_nettype wire

// File: rtl/fetch_buf.sv
/*
 * Return buffer of the fetch unit.
 * Two word slots with an age index, bypass of bus data when empty, and the
 * saved upper halfword used by the high and unaligned states.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_buf (
  input  wire                          clk_i,
  input  wire                          rst_an_i,
  input  wire fetch_pkg::mem_rsp_t     rsp_i,
  input  wire fetch_pkg::buf_cmd_t     cmd_i,
  input  wire fetch_pkg::fetch_state_e state_i,
  output fetch_pkg::insn_word_u        word_o,
  output logic [15:0]                  hi_half_o,
  output fetch_pkg::buf_stat_t         stat_o
);

  import fetch_pkg::*;

  localparam int DEPTH = `FETCH_BUF_DEPTH;

  logic [31:0]      slot_q [DEPTH];
  logic [DEPTH-1:0] valid_q;
  logic             idx_q;
  logic [15:0]      hi_q;
  logic [31:0]      bus_s;
  logic [31:0]      cur_s;

  // idle bus reads as zero so the decode stays quiet
  assign bus_s = rsp_i.rdy ? rsp_i.rdata : 32'h0;

  // ------------------------------------------------
  // fill and age bookkeeping
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_an_i) begin
    if (!rst_an_i) begin
      valid_q <= '0;
      idx_q   <= 1'b0;
    end else if (cmd_i.flush) begin
      valid_q <= '0;
    end else if (cmd_i.ext_save || cmd_i.clear) begin
      case (valid_q)
        2'b00: begin
          valid_q <= {1'b0, cmd_i.ext_save};
        end
        2'b01: begin
          // slot 0 older
          valid_q <= {cmd_i.ext_save, ~cmd_i.clear};
          idx_q   <= 1'b0;
        end
        2'b10: begin
          // slot 1 older
          valid_q <= {~cmd_i.clear, cmd_i.ext_save};
          idx_q   <= 1'b1;
        end
        default: begin
          // full, only the older slot drains
          if (cmd_i.clear) begin
            valid_q[idx_q] <= 1'b0;
          end
        end
      endcase
    end
  end

  // payload, write into the free slot
  always_ff @(posedge clk_i) begin
    if (cmd_i.ext_save && !cmd_i.flush) begin
      if (valid_q == 2'b01) begin
        slot_q[1] <= bus_s;
      end else if (valid_q != 2'b11) begin
        slot_q[0] <= bus_s;
      end
    end
    if (cmd_i.int_save) begin
      hi_q <= cur_s[31:16];
    end
  end

  // ------------------------------------------------
  // word selection
  // ------------------------------------------------
  always_comb begin
    case (valid_q)
      2'b00:   cur_s = bus_s;
      2'b01:   cur_s = slot_q[0];
      2'b10:   cur_s = slot_q[1];
      default: cur_s = idx_q ? slot_q[1] : slot_q[0];
    endcase
  end

  // high state puts the saved half on top of the next word
  assign word_o.op = (state_i == st_high) ? {hi_q, cur_s[15:0]} : cur_s;
  assign hi_half_o = hi_q;
  assign stat_o    = '{valid: valid_q, idx: idx_q};

endmodule

`default_nettype wire

// File: rtl/fetch_issue.sv
/*
 * Issue side of the fetch unit.
 * Builds the presented op from the current word and the saved half, flags
 * 32-bit versus compressed and keeps the pc of the presented instruction.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_issue (
  input  wire                          clk_i,
  input  wire                          rst_an_i,
  input  wire fetch_pkg::fetch_state_e state_i,
  input  wire fetch_pkg::insn_word_u   word_i,
  input  wire [15:0]                   hi_half_i,
  input  wire                          valid_i,
  input  wire                          advance_i,
  input  wire                          branch_i,
  input  wire [`FETCH_ADDR_W-1:0]      jump_addr_i,
  output logic [`FETCH_ADDR_W-1:0]     pc_o,
  output fetch_pkg::issue_t            issue_o
);

  import fetch_pkg::*;

  localparam int AW = `FETCH_ADDR_W;

  logic [AW-1:0] pc_q;
  logic [AW-1:0] pc_step_s;
  logic          rv_s;
  logic [31:0]   rv_op_s;
  logic [15:0]   rvc_op_s;
  logic [31:0]   op_s;

  // ------------------------------------------------
  // op classification
  // ------------------------------------------------
  // unaligned state always holds a 32-bit op
  // low state reads the low half, jump exit the high half
  assign rv_s = (state_i == st_unalign) ||
                ((state_i == st_low) && (word_i.half.lo[1:0] == 2'b11)) ||
                ((state_i == st_exit) && (word_i.half.hi[1:0] == 2'b11));

  // ------------------------------------------------
  // op assembly
  // ------------------------------------------------
  // halfword pc joins the saved upper half with the new low half
  assign rv_op_s = pc_q[1] ? {word_i.half.lo, hi_half_i} : word_i.op;

  // compressed op from the half the pc points at
  assign rvc_op_s = pc_q[1] ? word_i.half.hi : word_i.half.lo;

  // compressed ops zero-extended to a full word
  assign op_s = rv_s ? rv_op_s : {16'h0000, rvc_op_s};

  // ------------------------------------------------
  // program counter
  // ------------------------------------------------
  assign pc_step_s = rv_s ? AW'(4) : AW'(2);

  always_ff @(posedge clk_i or negedge rst_an_i) begin
    if (!rst_an_i) begin
      pc_q <= `FETCH_RESET_VEC;
    end else if (branch_i) begin
      // jump target may be halfword aligned
      pc_q <= jump_addr_i;
    end else if (advance_i) begin
      pc_q <= pc_q + pc_step_s;
    end
  end

  assign pc_o    = pc_q;
  assign issue_o = '{valid: valid_i, rv: rv_s, op: op_s, pc: pc_q};

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
/*
 * Instruction fetch unit top level.
 * Connects the FSM, request, buffer and issue blocks to the memory port
 * and to the consumer.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_top (
  input  wire                      clk_i,
  input  wire                      rst_an_i,
  // memory port
  output logic                     i_rd_o,
  output logic [`FETCH_ADDR_W-1:0] i_addr_o,
  input  wire                      i_grant_i,
  input  wire                      i_rdy_i,
  input  wire  [31:0]              i_rdata_i,
  // consumer
  input  wire                      stall_i,
  input  wire                      branch_i,
  input  wire  [`FETCH_ADDR_W-1:0] jump_addr_i,
  output logic                     if_valid_o,
  output logic                     if_rv_o,
  output logic [31:0]              if_op_o,
  output logic [`FETCH_ADDR_W-1:0] if_pc_o
);

  import fetch_pkg::*;

  mem_rsp_t                 rsp_s;
  buf_stat_t                stat_s;
  buf_cmd_t                 cmd_s;
  fetch_state_e             state_s;
  insn_word_u               word_s;
  logic [15:0]              hi_half_s;
  logic                     advance_s;
  logic                     valid_s;
  logic                     drop_s;
  logic [`FETCH_ADDR_W-1:0] pc_s;
  issue_t                   issue_s;

  assign rsp_s = '{rdy: i_rdy_i, rdata: i_rdata_i};

  fetch_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_an_i    (rst_an_i),
    .rsp_i       (rsp_s),
    .stat_i      (stat_s),
    .word_i      (word_s),
    .drop_i      (drop_s),
    .stall_i     (stall_i),
    .branch_i    (branch_i),
    .jump_half_i (jump_addr_i[1]),
    .state_o     (state_s),
    .advance_o   (advance_s),
    .valid_o     (valid_s),
    .cmd_o       (cmd_s)
  );

  fetch_req u_req (
    .clk_i       (clk_i),
    .rst_an_i    (rst_an_i),
    .state_i     (state_s),
    .stat_i      (stat_s),
    .rsp_i       (rsp_s),
    .branch_i    (branch_i),
    .jump_addr_i (jump_addr_i),
    .pc_i        (pc_s),
    .i_grant_i   (i_grant_i),
    .i_rd_o      (i_rd_o),
    .i_addr_o    (i_addr_o),
    .drop_o      (drop_s)
  );

  fetch_buf u_buf (
    .clk_i     (clk_i),
    .rst_an_i  (rst_an_i),
    .rsp_i     (rsp_s),
    .cmd_i     (cmd_s),
    .state_i   (state_s),
    .word_o    (word_s),
    .hi_half_o (hi_half_s),
    .stat_o    (stat_s)
  );

  fetch_issue u_issue (
    .clk_i       (clk_i),
    .rst_an_i    (rst_an_i),
    .state_i     (state_s),
    .word_i      (word_s),
    .hi_half_i   (hi_half_s),
    .valid_i     (valid_s),
    .advance_i   (advance_s),
    .branch_i    (branch_i),
    .jump_addr_i (jump_addr_i),
    .pc_o        (pc_s),
    .issue_o     (issue_s)
  );

  // consumer outputs
  assign if_valid_o = issue_s.valid;
  assign if_rv_o    = issue_s.rv;
  assign if_op_o    = issue_s.op;
  assign if_pc_o    = issue_s.pc;

endmodule

`default_nettype wire

// File: tests/imem_model.sv
/*
 * Instruction memory model for the fetch testbench.
 * Grants reads with random gaps and returns each word one to three cycles
 * after its grant. The testbench writes the image into mem before reset.
 */
`timescale 1ns/1ps
`default_nettype none

module imem_model #(
  parameter int WORDS = 64
) (
  input  wire         clk_i,
  input  wire         rst_an_i,
  input  wire         i_rd_i,
  input  wire  [31:0] i_addr_i,
  output logic        i_grant_o,
  output logic        i_rdy_o,
  output logic [31:0] i_rdata_o,
  output logic        err_o
);

  localparam int IDX_W = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  integer      seed;
  logic        busy;
  int          wait_cnt;
  logic [31:0] addr_q;

  initial begin
    seed      = 32'h22d8;
    busy      = 1'b0;
    wait_cnt  = 0;
    addr_q    = 32'h0;
    i_grant_o = 1'b0;
    i_rdy_o   = 1'b0;
    i_rdata_o = 32'h0;
    err_o     = 1'b0;
    forever begin
      // ------------------------------------------------
      // mid cycle, decide what the coming edge does
      // ------------------------------------------------
      @(negedge clk_i);
      // a return completes at the edge and frees the port
      if (i_rdy_o) begin
        busy = 1'b0;
      end
      if (rst_an_i && i_rd_i && i_grant_o) begin
        // only one fetch may be outstanding
        if (busy) begin
          err_o = 1'b1;
        end
        busy     = 1'b1;
        addr_q   = i_addr_i;
        wait_cnt = 1 + ($unsigned($random(seed)) % 3);
      end
      // ------------------------------------------------
      // drive the next cycle shortly after the edge
      // ------------------------------------------------
      @(posedge clk_i);
      #1;
      i_rdy_o   = 1'b0;
      i_rdata_o = 32'h0;
      if (busy) begin
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0) begin
          i_rdy_o   = 1'b1;
          i_rdata_o = mem[addr_q[IDX_W+1:2]];
        end
      end
      // grant about three cycles in four
      i_grant_o = rst_an_i && (($random(seed) & 3) != 0);
    end
  end

endmodule

`default_nettype wire

// File: tests/fetch_tb.sv
/*
 * Testbench of the instruction fetch unit.
 * Runs a table of expected instructions through the DUT with random stalls
 * and random memory timing, and checks each presented op, rv flag and pc.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb;

  localparam int N_ROWS     = 27;
  localparam int MAX_CYCLES = 40 * N_ROWS;
  localparam int MEM_WORDS  = 64;

  // one expected instruction, br jumps to the next row's pc after it
  typedef struct packed {
    logic [3:0]  test;
    logic        br;
    logic        rv;
    logic [31:0] pc;
    logic [31:0] op;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_an;
  logic        stall;
  logic        branch;
  logic [31:0] jump_addr;
  logic        i_rd;
  logic [31:0] i_addr;
  logic        i_grant;
  logic        i_rdy;
  logic [31:0] i_rdata;
  logic        if_valid;
  logic        if_rv;
  logic [31:0] if_op;
  logic [31:0] if_pc;
  logic        mem_err;

  row_t        rows [N_ROWS];
  integer      seed;
  int          n_rows;
  int          row_idx;
  int          test_rows;
  int          cycles;
  int          checks;
  int          errors;
  int          test_errors;
  logic        take_branch;
  logic        timed_out;
  logic        held;

  initial begin
    forever begin
      #4 clk = ~clk;
    end
  end

  fetch_top u_dut (
    .clk_i       (clk),
    .rst_an_i    (rst_an),
    .i_rd_o      (i_rd),
    .i_addr_o    (i_addr),
    .i_grant_i   (i_grant),
    .i_rdy_i     (i_rdy),
    .i_rdata_i   (i_rdata),
    .stall_i     (stall),
    .branch_i    (branch),
    .jump_addr_i (jump_addr),
    .if_valid_o  (if_valid),
    .if_rv_o     (if_rv),
    .if_op_o     (if_op),
    .if_pc_o     (if_pc)
  );

  imem_model #(.WORDS(MEM_WORDS)) u_mem (
    .clk_i     (clk),
    .rst_an_i  (rst_an),
    .i_rd_i    (i_rd),
    .i_addr_i  (i_addr),
    .i_grant_o (i_grant),
    .i_rdy_o   (i_rdy),
    .i_rdata_o (i_rdata),
    .err_o     (mem_err)
  );

  // ------------------------------------------------
  // table and memory image
  // ------------------------------------------------
  task automatic add_row(input logic [3:0] t, input logic [31:0] pc, input logic [31:0] op,
                         input logic rv, input logic br);
    rows[n_rows] = '{test: t, br: br, rv: rv, pc: pc, op: op};
    n_rows++;
  endtask

  task automatic write_half(input logic [31:0] addr, input logic [15:0] half);
    if (addr[1]) begin
      u_mem.mem[addr[7:2]][31:16] = half;
    end else begin
      u_mem.mem[addr[7:2]][15:0] = half;
    end
  endtask

  // fill words outside the programs differ at every address
  task automatic build_image();
    logic [31:0] addr;
    for (int w = 0; w < MEM_WORDS; w++) begin
      addr = w * 4;
      u_mem.mem[w] = (addr * 32'h9E37_79B9) ^ 32'h0F0F_3C3C;
    end
    // little endian halves, a 32-bit op may span two words
    for (int r = 0; r < n_rows; r++) begin
      write_half(rows[r].pc, rows[r].op[15:0]);
      if (rows[r].rv) begin
        write_half(rows[r].pc + 32'd2, rows[r].op[31:16]);
      end
    end
  endtask

  function automatic string test_name(input int t);
    case (t)
      1:       return "aligned 32-bit ops";
      2:       return "compressed pairs";
      3:       return "32-bit ops across words";
      4:       return "branch to aligned target";
      5:       return "branch to halfword target";
      default: return "unknown";
    endcase
  endfunction

  // ------------------------------------------------
  // checks
  // ------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("FAILED %s got %h expected %h (pc %h)", name, got, exp, if_pc);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_row(input row_t exp);
    check_val("if_pc_o", if_pc, exp.pc);
    check_val("if_op_o", if_op, exp.op);
    check_val("if_rv_o", {31'h0, if_rv}, {31'h0, exp.rv});
  endtask

  task automatic check_idle();
    check_val("i_rd_o", {31'h0, i_rd}, 32'h0);
    check_val("if_valid_o", {31'h0, if_valid}, 32'h0);
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %0d instructions, %0d errors", t, test_name(t), test_rows,
             test_errors);
    test_rows   = 0;
    test_errors = 0;
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    rst_an      = 1'b0;
    stall       = 1'b0;
    branch      = 1'b0;
    jump_addr   = 32'h0;
    seed        = 32'h22d8;
    n_rows      = 0;
    row_idx     = 0;
    test_rows   = 0;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    take_branch = 1'b0;
    timed_out   = 1'b0;
    held        = 1'b0;

    // test 1 starts at the reset vector
    add_row(4'd1, 32'h00, 32'h0010_0093, 1'b1, 1'b0);
    add_row(4'd1, 32'h04, 32'h0020_8113, 1'b1, 1'b0);
    add_row(4'd1, 32'h08, 32'h0031_0193, 1'b1, 1'b0);
    add_row(4'd1, 32'h0C, 32'h0041_8213, 1'b1, 1'b0);
    add_row(4'd1, 32'h10, 32'h0052_0293, 1'b1, 1'b1);
    add_row(4'd2, 32'h20, 32'h0000_0505, 1'b0, 1'b0);
    add_row(4'd2, 32'h22, 32'h0000_4581, 1'b0, 1'b0);
    add_row(4'd2, 32'h24, 32'h0000_8082, 1'b0, 1'b0);
    add_row(4'd2, 32'h26, 32'h0000_1141, 1'b0, 1'b0);
    add_row(4'd2, 32'h28, 32'h0000_0001, 1'b0, 1'b0);
    add_row(4'd2, 32'h2A, 32'h0000_C606, 1'b0, 1'b1);
    // ops at 0x42 and 0x46 span two words
    add_row(4'd3, 32'h40, 32'h0000_4501, 1'b0, 1'b0);
    add_row(4'd3, 32'h42, 32'h00A5_8593, 1'b1, 1'b0);
    add_row(4'd3, 32'h46, 32'h00B6_0613, 1'b1, 1'b0);
    add_row(4'd3, 32'h4A, 32'h0000_0605, 1'b0, 1'b0);
    add_row(4'd3, 32'h4C, 32'h00C6_8693, 1'b1, 1'b1);
    add_row(4'd4, 32'h60, 32'h00D7_0713, 1'b1, 1'b0);
    add_row(4'd4, 32'h64, 32'h00E7_8793, 1'b1, 1'b1);
    add_row(4'd4, 32'h80, 32'h00F8_0813, 1'b1, 1'b0);
    add_row(4'd4, 32'h84, 32'h0000_0485, 1'b0, 1'b0);
    add_row(4'd4, 32'h86, 32'h0000_0509, 1'b0, 1'b1);
    // halfword targets, first a 32-bit op, then a compressed one
    add_row(4'd5, 32'hA2, 32'h0109_0913, 1'b1, 1'b0);
    add_row(4'd5, 32'hA6, 32'h0000_0991, 1'b0, 1'b0);
    add_row(4'd5, 32'hA8, 32'h011A_0A13, 1'b1, 1'b1);
    add_row(4'd5, 32'hC6, 32'h0000_0A85, 1'b0, 1'b0);
    add_row(4'd5, 32'hC8, 32'h012B_0B13, 1'b1, 1'b0);
    add_row(4'd5, 32'hCC, 32'h0000_0B05, 1'b0, 1'b0);
    build_image();

    // reset over three rising edges, fetch side quiet throughout
    repeat (2) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    #1;
    rst_an = 1'b1;
    @(negedge clk);
    check_idle();

    while (row_idx < n_rows && !timed_out) begin
      @(posedge clk);
      #1;
      branch    = take_branch;
      jump_addr = take_branch ? rows[row_idx].pc : 32'h0;
      stall     = (($random(seed) & 3) == 0);
      @(negedge clk);
      cycles++;
      take_branch = 1'b0;
      // first request one cycle after release, at the reset vector
      if (cycles == 1) begin
        check_val("i_rd_o", {31'h0, i_rd}, 32'h1);
        check_val("i_addr_o", i_addr, `FETCH_RESET_VEC);
        $display("test 0 reset and first request: %0d errors", test_errors);
        test_errors = 0;
      end
      // a stalled instruction stays presented until it is consumed
      if (held) begin
        check_val("if_valid_o", {31'h0, if_valid}, 32'h1);
      end
      held = 1'b0;
      if (if_valid) begin
        check_row(rows[row_idx]);
        if (stall) begin
          held = 1'b1;
        end else begin
          take_branch = rows[row_idx].br;
          row_idx++;
          test_rows++;
          if (row_idx == n_rows) begin
            report_test(rows[row_idx-1].test);
          end else if (rows[row_idx].test != rows[row_idx-1].test) begin
            report_test(rows[row_idx-1].test);
          end
        end
      end
      if (cycles >= MAX_CYCLES) begin
        $display("timeout after %0d cycles, the DUT stopped presenting instructions",
                 cycles);
        errors++;
        timed_out = 1'b1;
      end
    end

    assert (!mem_err) else begin
      $display("memory model granted a second fetch while one was still outstanding");
      errors++;
    end
    $display("done: %0d checks, %0d errors, %0d of %0d instructions consumed", checks,
             errors, row_idx, n_rows);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/fetch_req.sv
rtl/fetch_buf.sv
rtl/fetch_issue.sv
rtl/fetch_top.sv
tests/imem_model.sv
tests/fetch_tb.sv

// File: run.sh
#!/bin/sh
# builds the fetch unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module fetch_tb -Mdir obj_dir

out=$(./obj_dir/Vfetch_tb)
echo "$out"

echo "$out" | grep -qx '>>> PASS'
